// ==== Makefile ====
# Verilator flow for the SPI subsystem testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_spi_subsys
FILELIST  := build.f
OBJ_DIR   := obj_dir
SIM_LOG   := sim.log
FAIL_MSG  := sim failed
PASS_MSG  := sim passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides the result, the simulator exit code is not trusted
run: compile
	./$(OBJ_DIR)/V$(TOP) > $(SIM_LOG) 2>&1; cat $(SIM_LOG)
	@if grep -q "$(FAIL_MSG)" $(SIM_LOG); then \
	  echo "simulation reported failure"; exit 1; \
	fi
	@grep -q "$(PASS_MSG)" $(SIM_LOG) || { echo "no result found in $(SIM_LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(SIM_LOG)

// ==== build.f ====
design/spi_pkg.sv
design/spi_edge_gen.sv
design/spi_controller.sv
design/spi_echo_target.sv
design/spi_subsys_top.sv
testbench/tb_spi_subsys.sv

// ==== design/spi_controller.sv ====
`timescale 1ns/1ps

module spi_controller (
  input  logic                             sclk,
  input  logic                             arst_n,
  input  logic                             req,
  input  spi_pkg::spi_mode_u               mode,
  input  logic                             target_sel,
  input  logic [spi_pkg::data_width-1:0]   tx_byte,
  input  logic                             lead,
  input  logic                             trail,
  input  logic                             poci,
  output logic                             ack,
  output logic [spi_pkg::data_width-1:0]   rx_byte,
  output logic                             run,
  output logic                             cpol,
  output logic                             pico,
  output logic [spi_pkg::num_targets-1:0]  cs
);
  import spi_pkg::*;

  logic [2:0]                state;
  logic [step_cnt_width-1:0] step_cnt;
  spi_mode_u                 mode_q;
  logic                      sel_q;
  logic [data_width-1:0]     tx_sr;
  logic [data_width-1:0]     rx_sr;
  logic                      accept;
  logic                      launch;
  logic                      sample;
  logic                      hold_end;

  assign accept   = (state == st_idle) && req;
  assign launch   = mode_q.bits.cpha ? lead : trail;
  assign sample   = mode_q.bits.cpha ? trail : lead;
  assign hold_end = (state == st_hold) &&
                    (step_cnt == step_cnt_width'(half_period_cycles - 1));
  assign cpol     = mode_q.bits.cpol;  // edge gen parks spi_clk one cycle later

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // handshake and sequencing FSM
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge sclk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= st_idle;
      step_cnt <= '0;
      mode_q   <= '0;
      sel_q    <= 1'b0;
      run      <= 1'b0;
      cs       <= '1;
      ack      <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (req) begin
            mode_q   <= mode;
            sel_q    <= target_sel;
            step_cnt <= '0;
            state    <= st_setup;
          end
        end
        st_setup: begin
          step_cnt <= step_cnt + 1'b1;
          // cs drops once spi_clk has settled at the new cpol
          if (step_cnt == step_cnt_width'(1))
            cs <= ~(num_targets'(1) << sel_q);
          if (step_cnt == step_cnt_width'(half_period_cycles + 1)) begin
            run      <= 1'b1;
            step_cnt <= '0;
            state    <= st_shift;
          end
        end
        st_shift: begin
          if (lead || trail) begin
            step_cnt <= step_cnt + 1'b1;
            if (step_cnt == step_cnt_width'(edges_per_transfer - 1)) begin
              run      <= 1'b0;  // last edge of the byte
              step_cnt <= '0;
              state    <= st_hold;
            end
          end
        end
        st_hold: begin
          step_cnt <= step_cnt + 1'b1;
          if (hold_end) begin
            cs    <= '1;
            ack   <= 1'b1;
            state <= st_done;
          end
        end
        st_done: begin
          if (!req) begin  // host finished with rx_byte
            ack   <= 1'b0;
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // shift engine
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge sclk or negedge arst_n) begin
    if (!arst_n)
      pico <= 1'b0;
    else if (accept)
      pico <= mode.bits.cpha ? 1'b0 : tx_byte[data_width-1];  // cpha 0 presets msb
    else if (state == st_shift && launch)
      pico <= tx_sr[data_width-1];
  end

  always_ff @(posedge sclk) begin
    if (accept)
      tx_sr <= mode.bits.cpha ? tx_byte : {tx_byte[data_width-2:0], 1'b0};
    else if (state == st_shift && launch)
      tx_sr <= {tx_sr[data_width-2:0], 1'b0};
    if (state == st_shift && sample)
      rx_sr <= {rx_sr[data_width-2:0], poci};  // msb first
    if (hold_end)
      rx_byte <= rx_sr;  // held until the next byte completes
  end

endmodule

// ==== design/spi_echo_target.sv ====
`timescale 1ns/1ps

module spi_echo_target #(
  parameter bit rise_capture = 1'b1  // 1: modes 0/3, 0: modes 1/2
) (
  input  logic spi_clk,
  input  logic arst_n,
  input  logic pico,
  input  logic cs,
  output logic poci
);
  import spi_pkg::*;

  logic [data_width-1:0] rx_data;
  logic                  tx_bit;
  logic                  cap_clk;

  // capture edge becomes a rising edge of cap_clk in both flavours
  assign cap_clk = rise_capture ? spi_clk : ~spi_clk;

  always_ff @(posedge cap_clk or negedge arst_n) begin
    if (!arst_n)
      rx_data <= '0;
    else if (!cs)
      rx_data <= {rx_data[data_width-2:0], pico};
  end

  // launch on the opposite edge
  always_ff @(negedge cap_clk or negedge arst_n) begin
    if (!arst_n)
      tx_bit <= 1'b0;
    else if (!cs)
      tx_bit <= rx_data[data_width-1];
  end

  // no tri-state, so drive low when deselected and let the top OR the targets
  assign poci = cs ? 1'b0 : tx_bit;

endmodule

// ==== design/spi_edge_gen.sv ====
`timescale 1ns/1ps

module spi_edge_gen (
  input  logic sclk,
  input  logic arst_n,
  input  logic run,
  input  logic cpol,
  output logic spi_clk,
  output logic lead,
  output logic trail
);
  import spi_pkg::*;

  logic [half_cnt_width-1:0] half_cnt;
  logic                      parity;    // 0 before a leading edge, 1 before a trailing one
  logic                      half_done;

  assign half_done = (half_cnt == half_cnt_width'(half_period_cycles - 1));

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // half period timer and spi_clk
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge sclk or negedge arst_n) begin
    if (!arst_n) begin
      half_cnt <= '0;
      parity   <= 1'b0;
      spi_clk  <= 1'b0;
      lead     <= 1'b0;
      trail    <= 1'b0;
    end else begin
      lead  <= 1'b0;  // strobes last one cycle
      trail <= 1'b0;
      if (!run) begin
        half_cnt <= '0;
        parity   <= 1'b0;
        spi_clk  <= cpol;  // park at idle level
      end else if (half_done) begin
        half_cnt <= '0;
        spi_clk  <= ~spi_clk;
        parity   <= ~parity;
        lead     <= ~parity;
        trail    <= parity;
      end else begin
        half_cnt <= half_cnt + 1'b1;
      end
    end
  end

  // the strobes rise in the same cycle as the spi_clk transition they mark,
  // so the controller sees them one sclk cycle after the target saw the edge.
  // an even number of toggles per byte leaves spi_clk at cpol when run drops

endmodule

// ==== design/spi_pkg.sv ====
package spi_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // bus geometry and timing
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int data_width         = 8;   // bits per transfer
  localparam int num_targets        = 2;   // one cs line each
  localparam int half_period_cycles = 4;   // sclk cycles per spi_clk half period
  localparam int edges_per_transfer = 16;  // two spi_clk edges per bit

  // counter widths
  localparam int half_cnt_width = $clog2(half_period_cycles);
  localparam int step_cnt_width = $clog2(edges_per_transfer);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // controller state codes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam logic [2:0] st_idle  = 3'd0;
  localparam logic [2:0] st_setup = 3'd1;  // cs asserted, clock parked
  localparam logic [2:0] st_shift = 3'd2;  // spi_clk running
  localparam logic [2:0] st_hold  = 3'd3;  // trailing half period before cs release
  localparam logic [2:0] st_done  = 3'd4;

  // spi mode word, seen either as mode number 0..3 or as its two control bits
  typedef union packed {
    logic [1:0] num;
    struct packed {
      logic cpol;  // idle level of spi_clk
      logic cpha;  // 1: launch on leading edge, sample on trailing
    } bits;
  } spi_mode_u;

endpackage

// ==== design/spi_subsys_top.sv ====
`timescale 1ns/1ps

module spi_subsys_top (
  input  logic                             sclk,
  input  logic                             arst_n,
  input  logic                             req,
  input  logic [1:0]                       mode,
  input  logic                             target_sel,
  input  logic [spi_pkg::data_width-1:0]   tx_byte,
  output logic                             ack,
  output logic [spi_pkg::data_width-1:0]   rx_byte,
  output logic                             spi_clk,
  output logic                             pico,
  output logic [spi_pkg::num_targets-1:0]  cs
);
  import spi_pkg::*;

  spi_mode_u mode_w;
  logic      run;
  logic      cpol;
  logic      lead;
  logic      trail;
  logic      poci_0;
  logic      poci_1;
  logic      poci;

  assign mode_w.num = mode;            // host gives a plain mode number
  assign poci       = poci_0 | poci_1; // deselected targets hold poci low

  spi_controller spi_controller_inst (
    .sclk       (sclk),
    .arst_n     (arst_n),
    .req        (req),
    .mode       (mode_w),
    .target_sel (target_sel),
    .tx_byte    (tx_byte),
    .lead       (lead),
    .trail      (trail),
    .poci       (poci),
    .ack        (ack),
    .rx_byte    (rx_byte),
    .run        (run),
    .cpol       (cpol),
    .pico       (pico),
    .cs         (cs)
  );

  spi_edge_gen spi_edge_gen_inst (
    .sclk    (sclk),
    .arst_n  (arst_n),
    .run     (run),
    .cpol    (cpol),
    .spi_clk (spi_clk),
    .lead    (lead),
    .trail   (trail)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // echo targets
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  spi_echo_target #(.rise_capture(1'b1)) spi_echo_modes03_inst (
    .spi_clk (spi_clk),
    .arst_n  (arst_n),
    .pico    (pico),
    .cs      (cs[0]),
    .poci    (poci_0)
  );

  spi_echo_target #(.rise_capture(1'b0)) spi_echo_modes12_inst (
    .spi_clk (spi_clk),
    .arst_n  (arst_n),
    .pico    (pico),
    .cs      (cs[1]),
    .poci    (poci_1)
  );

endmodule

// ==== testbench/tb_spi_subsys.sv ====
`timescale 1ns/1ps

module tb_spi_subsys;
  import spi_pkg::*;

  localparam int ack_timeout   = 200;  // in sclk cycles against roughly 80 per byte
  localparam int drain_timeout = 10;

  logic                        sclk;
  logic                        arst_n;
  logic                        req;
  logic [1:0]                  mode;
  logic                        target_sel;
  logic [data_width-1:0]       tx_byte;
  logic                        ack;
  logic [data_width-1:0]       rx_byte;
  logic                        spi_clk;
  logic                        pico;
  logic [num_targets-1:0]      cs;

  integer seed;
  int     checks;
  int     errors;
  int     test_base;  // error count when the current test started
  logic   cur_sel;
  bit     in_xfer;    // cs monitor expects one line low
  bit     cs_seen;

  // echo history per target
  logic [data_width-1:0] last_byte [num_targets];
  logic [1:0]            last_mode [num_targets];

  // finished transfers waiting for the checker
  logic [data_width-1:0] got_q  [$];
  logic [data_width-1:0] exp_q  [$];
  logic [data_width-1:0] mask_q [$];

  spi_subsys_top spi_subsys_top_inst (
    .sclk       (sclk),
    .arst_n     (arst_n),
    .req        (req),
    .mode       (mode),
    .target_sel (target_sel),
    .tx_byte    (tx_byte),
    .ack        (ack),
    .rx_byte    (rx_byte),
    .spi_clk    (spi_clk),
    .pico       (pico),
    .cs         (cs)
  );

  always #5 sclk = ~sclk;  // 10 ns period

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reference model and reporting
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // a target returns the byte it got last time; the history moves on here
  function automatic logic [data_width-1:0] echo_expect(
    input  logic                  sel,
    input  logic [1:0]            m,
    input  logic [data_width-1:0] tx,
    output logic [data_width-1:0] mask
  );
    logic [data_width-1:0] exp_v;
    exp_v = last_byte[sel];
    mask  = '1;
    // a cpha 0 byte samples the bit launched at the end of the previous byte.
    // after a cpha 1 byte that launch came before the last capture, so bit 7 is stale
    if (last_mode[sel][0] && !m[0])
      mask[data_width-1] = 1'b0;
    last_byte[sel] = tx;
    last_mode[sel] = m;
    return exp_v;
  endfunction

  function automatic logic [data_width-1:0] rand_byte();
    return 8'($random(seed));
  endfunction

  task automatic report_mismatch(input string msg);
    errors++;
    $display("MISMATCH at %0t: %s", $time, msg);
  endtask

  task automatic report_failure(input string msg);
    errors++;
    $display("%s", msg);
  endtask

  task automatic wait_ack(input logic level);
    int n;
    n = 0;
    while (ack !== level && n < ack_timeout) begin
      @(negedge sclk);
      n++;
    end
    if (ack !== level) begin
      $display("timeout: ack did not reach %b within %0d cycles", level, ack_timeout);
      $display("sim failed");
      $finish;
    end
  endtask

  // one host transaction with req held hold_cycles extra cycles after ack
  task automatic do_transfer(input logic sel, input logic [1:0] m,
                             input logic [data_width-1:0] tx, input int hold_cycles);
    logic [data_width-1:0] exp_v;
    logic [data_width-1:0] mask_v;
    exp_v = echo_expect(sel, m, tx, mask_v);
    @(negedge sclk);
    target_sel = sel;
    mode       = m;
    tx_byte    = tx;
    cur_sel    = sel;
    cs_seen    = 1'b0;
    in_xfer    = 1'b1;
    req        = 1'b1;
    wait_ack(1'b1);
    in_xfer = 1'b0;
    checks += 2;
    if (spi_clk !== m[1])
      report_mismatch($sformatf("spi_clk %b after ack, expected cpol %b of mode %0d",
                                spi_clk, m[1], m));
    if (!cs_seen)
      report_failure($sformatf("no cs line went low during a transfer to target %0d", sel));
    got_q.push_back(rx_byte);
    exp_q.push_back(exp_v);
    mask_q.push_back(mask_v);
    repeat (hold_cycles) begin
      @(negedge sclk);
      checks++;
      if (ack !== 1'b1 || cs !== 2'b11)
        report_mismatch($sformatf("ack %b cs %b while req is still held", ack, cs));
    end
    req = 1'b0;
    wait_ack(1'b0);
  endtask

  task automatic finish_test(input int num, input string name);
    int n;
    n = 0;
    while (got_q.size() != 0 && n < drain_timeout) begin
      @(negedge sclk);
      n++;
    end
    if (got_q.size() != 0)
      report_failure("checker left transfer results unread at the end of a test");
    if (errors == test_base)
      $display("test %0d %s: ok", num, name);
    else
      $display("test %0d %s: %0d errors", num, name, errors - test_base);
    test_base = errors;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // checker and cs monitor
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always @(negedge sclk) begin
    logic [data_width-1:0] got;
    logic [data_width-1:0] exp_v;
    logic [data_width-1:0] mask;
    if (got_q.size() != 0) begin
      got   = got_q.pop_front();
      exp_v = exp_q.pop_front();
      mask  = mask_q.pop_front();
      checks++;
      if ((got & mask) !== (exp_v & mask))
        report_mismatch($sformatf("rx_byte %h, expected %h under mask %h", got, exp_v, mask));
    end
  end

  always @(negedge sclk) begin
    if (in_xfer && cs !== 2'b11) begin
      if (cs !== (cur_sel ? 2'b01 : 2'b10))  // target 0 sits on cs[0], target 1 on cs[1]
        report_mismatch($sformatf("cs %b while target %0d is selected", cs, cur_sel));
      else
        cs_seen = 1'b1;
    end else if (!in_xfer && arst_n && cs !== 2'b11) begin
      report_mismatch($sformatf("cs %b outside a transfer", cs));
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // test sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin
    int         hold;
    logic       sel;
    logic [1:0] m;
    $timeformat(-9, 0, " ns", 0);
    sclk       = 1'b0;
    arst_n     = 1'b0;
    req        = 1'b0;
    mode       = 2'd0;
    target_sel = 1'b0;
    tx_byte    = '0;
    seed       = 32'h41cf;
    checks     = 0;
    errors     = 0;
    test_base  = 0;
    cur_sel    = 1'b0;
    in_xfer    = 1'b0;
    cs_seen    = 1'b0;
    for (int t = 0; t < num_targets; t++) begin
      last_byte[t] = '0;  // echo registers clear on reset
      last_mode[t] = 2'd0;
    end
    repeat (4) @(negedge sclk);
    arst_n = 1'b1;
    @(negedge sclk);

    checks += 4;
    if (ack !== 1'b0)
      report_mismatch($sformatf("ack %b after reset", ack));
    if (cs !== 2'b11)
      report_mismatch($sformatf("cs %b after reset", cs));
    if (spi_clk !== 1'b0)
      report_mismatch($sformatf("spi_clk %b after reset", spi_clk));
    if (pico !== 1'b0)
      report_mismatch($sformatf("pico %b after reset", pico));
    finish_test(1, "reset state");

    for (int i = 0; i < 6; i++)
      do_transfer(1'b0, 2'd0, rand_byte(), 0);
    finish_test(2, "target 0 mode 0 echo");

    for (int i = 0; i < 8; i++)
      do_transfer(1'b1, (i % 2 == 0) ? 2'd1 : 2'd2, rand_byte(), 0);
    finish_test(3, "target 1 modes 1 and 2");

    for (int i = 0; i < 24; i++) begin
      sel = 1'($random(seed));
      m   = sel ? ($random(seed) & 1 ? 2'd2 : 2'd1) : ($random(seed) & 1 ? 2'd3 : 2'd0);
      do_transfer(sel, m, rand_byte(), 0);
    end
    finish_test(4, "interleaved targets");

    for (int i = 0; i < 8; i++) begin
      m = 2'(i / 2);
      do_transfer(m == 2'd1 || m == 2'd2, m, rand_byte(), 0);
    end
    finish_test(5, "cs and spi_clk per mode");

    for (int i = 0; i < 6; i++) begin
      sel  = 1'($random(seed));
      m    = sel ? 2'd1 : 2'd0;
      hold = 5 + int'($random(seed) & 32'h1f);  // host slow to drop req
      do_transfer(sel, m, rand_byte(), hold);
    end
    finish_test(6, "req held after ack");

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule
